/* logic/fc_pkg.sv */
`default_nettype none

package fc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // layer dimensions and datapath widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int MAX_IN  = 64;
    localparam int MAX_OUT = 64;

    localparam int IN_AW  = $clog2(MAX_IN);   // input buffer pointer
    localparam int OUT_AW = $clog2(MAX_OUT);  // result buffer pointer

    // weight for output o and input i lives at o * MAX_IN + i
    localparam int W_AW = 12;

    localparam int ACC_W = 24;  // holds 64 full-scale int8 products with headroom

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host address map and engine states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // region tag sits in word address bits 19:17, values not listed are unmapped
    typedef enum logic [2:0] {
        TAG_FC_WEIGHT   = 3'd1,
        TAG_FC_INPUT    = 3'd2,
        TAG_FC_DATA_BUF = 3'd4,
        TAG_CTRL        = 3'd6
    } host_tag_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN   // waits for the requant pipeline to empty
    } eng_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shared bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one write into any of the byte buffers, narrow buffers use the low ptr bits
    typedef struct packed {
        logic            wren;
        logic [W_AW-1:0] ptr;
        logic [7:0]      data;
    } buf_wr_t;

    // layer setup as written by the host, counts run from 1 to 64
    typedef struct packed {
        logic [6:0] in_count;
        logic [6:0] out_count;
        logic [3:0] shift;
    } fc_cfg_t;

    // finished sum for one output neuron
    typedef struct packed {
        logic                    valid;
        logic [OUT_AW-1:0]       idx;
        logic signed [ACC_W-1:0] acc;
    } acc_item_t;

endpackage

`default_nettype wire

/* logic/buffer_ram.sv */
`default_nettype none

module buffer_ram #(
    parameter int DEPTH_AW = 6,
    parameter int WIDTH    = 8
) (
    input  logic                clk_i,
    input  fc_pkg::buf_wr_t     wr_i,
    input  logic [DEPTH_AW-1:0] rdptr_i,
    output logic [WIDTH-1:0]    rdata_o
);

    logic [WIDTH-1:0] mem_q [2**DEPTH_AW];

    // write port, takes only as many pointer bits as the depth needs
    always_ff @(posedge clk_i) begin
        if (wr_i.wren) begin
            mem_q[wr_i.ptr[DEPTH_AW-1:0]] <= wr_i.data[WIDTH-1:0];
        end
    end

    // registered read, data follows the pointer by one cycle
    always_ff @(posedge clk_i) begin
        rdata_o <= mem_q[rdptr_i];
    end

endmodule

`default_nettype wire

/* logic/addr_decoder.sv */
`default_nettype none

module addr_decoder (
    input  logic                      clk_i,
    input  logic                      reset_i,

    // host memory port
    input  logic                      en_i,
    input  logic [3:0]                we_i,
    input  logic [21:0]               addr_i,
    input  logic [31:0]               wrdata_i,
    output logic [31:0]               rddata_o,

    // result buffer read side
    input  logic [7:0]                result_rdata_i,
    output logic [fc_pkg::OUT_AW-1:0] result_rdptr_o,

    // engine status
    input  logic                      busy_i,

    // buffer writes and layer control
    output fc_pkg::buf_wr_t           weight_wr_o,
    output fc_pkg::buf_wr_t           input_wr_o,
    output logic                      start_o,
    output fc_pkg::fc_cfg_t           cfg_o
);

    import fc_pkg::*;

    logic [19:0]       word_addr;
    host_tag_e         tag;
    logic              host_wr;
    logic              host_rd;

    logic [2:0]        rd_tag_q;   // region of the last read
    logic              rd_busy_q;
    logic [OUT_AW-1:0] rd_ptr_q;

    assign word_addr = addr_i[21:2];
    assign tag       = host_tag_e'(word_addr[19:17]);
    assign host_wr   = en_i && we_i[0];
    assign host_rd   = en_i && !we_i[0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // control word layout, the engine latches it on the start pulse
    assign cfg_o = '{
        in_count:  wrdata_i[6:0],
        out_count: wrdata_i[14:8],
        shift:     wrdata_i[19:16]
    };

    always_comb begin
        weight_wr_o = '0;
        input_wr_o  = '0;
        start_o     = 1'b0;
        if (host_wr) begin
            case (tag)
                TAG_FC_WEIGHT: begin
                    weight_wr_o.wren = 1'b1;
                    weight_wr_o.ptr  = word_addr[W_AW-1:0];
                    weight_wr_o.data = wrdata_i[7:0];
                end
                TAG_FC_INPUT: begin
                    input_wr_o.wren = 1'b1;
                    input_wr_o.ptr  = word_addr[W_AW-1:0];
                    input_wr_o.data = wrdata_i[7:0];
                end
                TAG_CTRL: start_o = 1'b1;
                default: ;  // unmapped regions drop the write
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_tag_q  <= 3'd0;  // unmapped, so read data starts at zero
            rd_busy_q <= 1'b0;
        end else if (host_rd) begin
            rd_tag_q  <= tag;
            rd_busy_q <= busy_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (host_rd) begin
            rd_ptr_q <= word_addr[OUT_AW-1:0];
        end
    end

    // between reads the RAM keeps reading the last pointer so the data holds
    assign result_rdptr_o = host_rd ? word_addr[OUT_AW-1:0] : rd_ptr_q;

    always_comb begin
        case (rd_tag_q)
            TAG_FC_DATA_BUF: rddata_o = {{24{result_rdata_i[7]}}, result_rdata_i};
            TAG_CTRL:        rddata_o = {31'd0, rd_busy_q};
            default:         rddata_o = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/fc_engine.sv */
`default_nettype none

module fc_engine (
    input  logic                     clk_i,
    input  logic                     reset_i,

    input  logic                     start_i,
    input  fc_pkg::fc_cfg_t          cfg_i,

    // buffer read ports
    output logic [fc_pkg::W_AW-1:0]  weight_rdptr_o,
    input  logic [7:0]               weight_rdata_i,
    output logic [fc_pkg::IN_AW-1:0] input_rdptr_o,
    input  logic [7:0]               input_rdata_i,

    // to requant
    output fc_pkg::acc_item_t        acc_o,
    output logic [3:0]               shift_o,

    output logic                     busy_o
);

    import fc_pkg::*;

    eng_state_e              state_q;
    fc_cfg_t                 cfg_q;
    logic                    issue_q;     // reads still going out for this output
    logic [1:0]              drain_cnt_q;

    logic [IN_AW-1:0]        in_idx_q;
    logic [OUT_AW-1:0]       out_idx_q;
    logic [6:0]              last_in;
    logic [6:0]              last_out;
    logic                    in_last;
    logic                    out_last;
    logic                    issuing;

    // read data pipeline flags trail the read pointer by one cycle
    logic                    d1_vld_q;
    logic                    d1_last_q;

    logic signed [15:0]      prod;
    logic signed [ACC_W-1:0] acc_q;
    logic signed [ACC_W-1:0] acc_sum;

    logic                    acc_vld_q;
    logic [OUT_AW-1:0]       acc_idx_q;
    logic signed [ACC_W-1:0] acc_sum_q;

    assign last_in  = cfg_q.in_count - 7'd1;
    assign last_out = cfg_q.out_count - 7'd1;
    assign in_last  = {1'b0, in_idx_q} == last_in;
    assign out_last = {1'b0, out_idx_q} == last_out;
    assign issuing  = (state_q == ST_RUN) && issue_q;

    assign weight_rdptr_o = {out_idx_q, in_idx_q};  // o * MAX_IN + i
    assign input_rdptr_o  = in_idx_q;

    assign prod    = $signed({{8{weight_rdata_i[7]}}, weight_rdata_i})
                   * $signed({{8{input_rdata_i[7]}}, input_rdata_i});
    assign acc_sum = acc_q + {{(ACC_W-16){prod[15]}}, prod};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= ST_IDLE;
            issue_q     <= 1'b0;
            drain_cnt_q <= 2'd0;
            d1_vld_q    <= 1'b0;
            d1_last_q   <= 1'b0;
            acc_vld_q   <= 1'b0;
        end else begin
            d1_vld_q  <= issuing;
            d1_last_q <= issuing && in_last;
            acc_vld_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q <= ST_RUN;
                        issue_q <= 1'b1;
                    end
                end
                ST_RUN: begin
                    if (issuing && in_last) begin
                        issue_q <= 1'b0;  // wait for this sum before the next output
                    end
                    if (d1_vld_q && d1_last_q) begin
                        acc_vld_q <= 1'b1;
                        if (out_last) begin
                            state_q     <= ST_DRAIN;
                            drain_cnt_q <= 2'd0;
                        end else begin
                            issue_q <= 1'b1;
                        end
                    end
                end
                ST_DRAIN: begin
                    // covers the item cycle and both requant stages
                    drain_cnt_q <= drain_cnt_q + 2'd1;
                    if (drain_cnt_q == 2'd2) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // counters and accumulator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && start_i) begin
            cfg_q     <= cfg_i;
            in_idx_q  <= '0;
            out_idx_q <= '0;
            acc_q     <= '0;
        end else begin
            if (issuing && !in_last) begin
                in_idx_q <= in_idx_q + 1'b1;
            end
            if (d1_vld_q) begin
                if (d1_last_q) begin
                    acc_sum_q <= acc_sum;      // last product folded in here
                    acc_idx_q <= out_idx_q;
                    acc_q     <= '0;
                    in_idx_q  <= '0;
                    out_idx_q <= out_idx_q + 1'b1;
                end else begin
                    acc_q <= acc_sum;
                end
            end
        end
    end

    assign acc_o = '{valid: acc_vld_q, idx: acc_idx_q, acc: acc_sum_q};
    assign shift_o = cfg_q.shift;
    assign busy_o  = state_q != ST_IDLE;

endmodule

`default_nettype wire

/* logic/fc_requant.sv */
`default_nettype none

module fc_requant (
    input  logic              clk_i,
    input  logic              reset_i,
    input  fc_pkg::acc_item_t acc_i,
    input  logic [3:0]        shift_i,
    output fc_pkg::buf_wr_t   result_wr_o
);

    import fc_pkg::*;

    // stage one, arithmetic shift
    logic                    s1_vld_q;
    logic [OUT_AW-1:0]       s1_idx_q;
    logic signed [ACC_W-1:0] s1_val_q;

    // stage two, saturated byte and result write
    logic                    wr_vld_q;
    logic [OUT_AW-1:0]       wr_idx_q;
    logic [7:0]              wr_data_q;
    logic [7:0]              sat;

    always_comb begin
        if (s1_val_q > 24'sd127) begin
            sat = 8'h7f;
        end else if (s1_val_q < -24'sd128) begin
            sat = 8'h80;
        end else begin
            sat = s1_val_q[7:0];  // already in int8 range
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_vld_q <= 1'b0;
            wr_vld_q <= 1'b0;
        end else begin
            s1_vld_q <= acc_i.valid;
            wr_vld_q <= s1_vld_q;
        end
    end

    // items arrive at most one per cycle, so both stages just advance
    always_ff @(posedge clk_i) begin
        s1_idx_q  <= acc_i.idx;
        s1_val_q  <= $signed(acc_i.acc) >>> shift_i;
        wr_idx_q  <= s1_idx_q;
        wr_data_q <= sat;
    end

    assign result_wr_o = '{
        wren: wr_vld_q,
        ptr:  W_AW'(wr_idx_q),
        data: wr_data_q
    };

endmodule

`default_nettype wire

/* logic/fc_top.sv */
`default_nettype none

module fc_top (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        en_i,
    input  logic [3:0]  we_i,
    input  logic [21:0] addr_i,
    input  logic [31:0] wrdata_i,
    output logic [31:0] rddata_o
);

    import fc_pkg::*;

    buf_wr_t           weight_wr;
    buf_wr_t           input_wr;
    buf_wr_t           result_wr;

    fc_cfg_t           cfg;
    logic              start;
    logic              busy;

    logic [W_AW-1:0]   weight_rdptr;
    logic [IN_AW-1:0]  input_rdptr;
    logic [OUT_AW-1:0] result_rdptr;
    logic [7:0]        weight_rdata;
    logic [7:0]        input_rdata;
    logic [7:0]        result_rdata;

    acc_item_t         acc_item;
    logic [3:0]        shift;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    addr_decoder u_decoder (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .en_i           (en_i),
        .we_i           (we_i),
        .addr_i         (addr_i),
        .wrdata_i       (wrdata_i),
        .rddata_o       (rddata_o),
        .result_rdata_i (result_rdata),
        .result_rdptr_o (result_rdptr),
        .busy_i         (busy),
        .weight_wr_o    (weight_wr),
        .input_wr_o     (input_wr),
        .start_o        (start),
        .cfg_o          (cfg)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // buffers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    buffer_ram #(.DEPTH_AW(W_AW), .WIDTH(8)) u_weight_buf (
        .clk_i   (clk_i),
        .wr_i    (weight_wr),
        .rdptr_i (weight_rdptr),
        .rdata_o (weight_rdata)
    );

    buffer_ram #(.DEPTH_AW(IN_AW), .WIDTH(8)) u_input_buf (
        .clk_i   (clk_i),
        .wr_i    (input_wr),
        .rdptr_i (input_rdptr),
        .rdata_o (input_rdata)
    );

    // written by requant, read back by the host
    buffer_ram #(.DEPTH_AW(OUT_AW), .WIDTH(8)) u_result_buf (
        .clk_i   (clk_i),
        .wr_i    (result_wr),
        .rdptr_i (result_rdptr),
        .rdata_o (result_rdata)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    fc_engine u_engine (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .start_i        (start),
        .cfg_i          (cfg),
        .weight_rdptr_o (weight_rdptr),
        .weight_rdata_i (weight_rdata),
        .input_rdptr_o  (input_rdptr),
        .input_rdata_i  (input_rdata),
        .acc_o          (acc_item),
        .shift_o        (shift),
        .busy_o         (busy)
    );

    fc_requant u_requant (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .acc_i       (acc_item),
        .shift_i     (shift),
        .result_wr_o (result_wr)
    );

endmodule

`default_nettype wire

/* test/tb_fc_top.sv */
`default_nettype none

module tb_fc_top;

    import fc_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int STIM_WORDS    = 256;
    localparam int ROW_STRIDE    = 64;  // weight for (o, i) sits at o * 64 + i
    localparam int RANDOM_LAYERS = 2;
    localparam int NUM_LAYERS    = 3 + RANDOM_LAYERS;

    // loading every weight and input, the run, result reads and polling
    localparam int WORST_LAYER_CYCLES = 2 * 64 * 64 + 2 * 64 + 2 * 64 * 66 + 3 * 64 + 64;
    localparam longint TIMEOUT =
        longint'(NUM_LAYERS) * WORST_LAYER_CYCLES * CLK_PERIOD + 2000 * CLK_PERIOD;

    logic        clk_i;
    logic        reset_i;
    logic        en_i;
    logic [3:0]  we_i;
    logic [21:0] addr_i;
    logic [31:0] wrdata_i;
    logic [31:0] rddata_o;

    logic [31:0]       stim [STIM_WORDS];
    logic signed [7:0] w_mem [ROW_STRIDE * ROW_STRIDE];
    logic signed [7:0] x_mem [ROW_STRIDE];
    logic [31:0]       seed;

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    fc_top uut (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .en_i     (en_i),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .wrdata_i (wrdata_i),
        .rddata_o (rddata_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, expected);
            $display("Checks failed");
            $fatal(1, "stopping at the first wrong value");
        end
    endtask

    task automatic host_write(input logic [2:0] tag, input logic [16:0] word,
                              input logic [31:0] data);
        @(posedge clk_i);
        en_i     <= 1'b1;
        we_i     <= 4'hf;
        addr_i   <= {tag, word, 2'b00};
        wrdata_i <= data;
        @(posedge clk_i);  // the write lands here
        en_i <= 1'b0;
        we_i <= 4'h0;
    endtask

    task automatic host_read(input logic [2:0] tag, input logic [16:0] word,
                             output logic [31:0] data);
        @(posedge clk_i);
        en_i   <= 1'b1;
        we_i   <= 4'h0;
        addr_i <= {tag, word, 2'b00};
        @(posedge clk_i);
        en_i <= 1'b0;
        @(negedge clk_i);  // read data is settled one cycle after the read edge
        data = rddata_o;
    endtask

    task automatic wait_idle(output logic first_busy);
        logic [31:0] status;
        host_read(TAG_CTRL, 17'd0, status);
        first_busy = status[0];
        while (status[0]) begin
            host_read(TAG_CTRL, 17'd0, status);
        end
        check("ctrl status", status, 32'd0);
    endtask

    task automatic start_layer(input logic [31:0] cfg);
        logic first_busy;
        host_write(TAG_CTRL, 17'd0, cfg);
        wait_idle(first_busy);
        check("busy on first poll", {31'd0, first_busy}, 32'd1);
    endtask

    // loads one layer from the file unless it is already in the buffers
    task automatic run_file_layer(input int base, input bit load, output int next);
        logic [31:0] cfg;
        logic [31:0] got;
        int          n_in;
        int          n_out;
        int          p;
        cfg   = stim[base];
        n_in  = int'(cfg[6:0]);
        n_out = int'(cfg[14:8]);
        p     = base + 1;
        for (int o = 0; o < n_out; o++) begin
            for (int i = 0; i < n_in; i++) begin
                if (load) host_write(TAG_FC_WEIGHT, 17'(o * ROW_STRIDE + i), stim[p]);
                p++;
            end
        end
        for (int i = 0; i < n_in; i++) begin
            if (load) host_write(TAG_FC_INPUT, 17'(i), stim[p]);
            p++;
        end
        start_layer(cfg);
        for (int o = 0; o < n_out; o++) begin
            host_read(TAG_FC_DATA_BUF, 17'(o), got);
            check($sformatf("result[%0d]", o), got,
                  {{24{stim[p + o][7]}}, stim[p + o][7:0]});  // host sees it sign-extended
        end
        next = p + n_out;
    endtask

    task automatic run_random_layer();
        int          n_in;
        int          n_out;
        int          shift;
        int          sum;
        logic [31:0] got;
        seed  = xorshift(seed);
        n_in  = int'(seed[5:0]) + 1;
        n_out = int'(seed[13:8]) + 1;
        shift = int'(seed[19:16]);
        for (int o = 0; o < n_out; o++) begin
            for (int i = 0; i < n_in; i++) begin
                seed = xorshift(seed);
                w_mem[o * ROW_STRIDE + i] = seed[7:0];
                host_write(TAG_FC_WEIGHT, 17'(o * ROW_STRIDE + i), seed);  // upper bits ignored
            end
        end
        for (int i = 0; i < n_in; i++) begin
            seed = xorshift(seed);
            x_mem[i] = seed[7:0];
            host_write(TAG_FC_INPUT, 17'(i), seed);
        end
        start_layer({12'd0, 4'(shift), 1'b0, 7'(n_out), 1'b0, 7'(n_in)});
        for (int o = 0; o < n_out; o++) begin
            sum = 0;
            for (int i = 0; i < n_in; i++) begin
                sum += int'(w_mem[o * ROW_STRIDE + i]) * int'(x_mem[i]);
            end
            sum = sum >>> shift;
            if (sum > 127) sum = 127;
            else if (sum < -128) sum = -128;
            host_read(TAG_FC_DATA_BUF, 17'(o), got);
            check($sformatf("random result[%0d]", o), got, 32'(sum));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int          sat_base;
        int          next;
        logic [31:0] data;
        seed     = 32'h0f1acf46;
        reset_i  <= 1'b1;
        en_i     <= 1'b0;
        we_i     <= 4'h0;
        addr_i   <= 22'd0;
        wrdata_i <= 32'd0;
        $readmemh("test/fc_stimulus.txt", stim);
        if ($isunknown(stim[0])) begin
            $display("the stimulus file test/fc_stimulus.txt could not be read");
            $display("Checks failed");
            $fatal(1, "no stimulus");
        end
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check("rddata after reset", rddata_o, 32'd0);
        host_read(TAG_CTRL, 17'd0, data);
        check("ctrl after reset", data, 32'd0);

        run_file_layer(0, 1'b1, sat_base);

        // none of these may touch the buffers
        host_write(3'd0, 17'd0, 32'h0000007f);
        host_write(3'd3, 17'd1, 32'h0000007f);
        host_write(3'd7, 17'd2, 32'h00000080);
        host_write(TAG_FC_DATA_BUF, 17'd0, 32'h00000055);
        host_read(3'd3, 17'd0, data);
        check("unmapped read", data, 32'd0);
        run_file_layer(0, 1'b0, sat_base);

        run_file_layer(sat_base, 1'b1, next);
        for (int r = 0; r < RANDOM_LAYERS; r++) begin
            run_random_layer();
        end
        $display("All checks passed");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("Checks failed");
        $fatal(1, "timeout, the layers did not finish in the expected time");
    end

endmodule

`default_nettype wire

/* test/fc_stimulus.txt */
// each layer: control word {shift[19:16], out_count[14:8], in_count[6:0]},
// then weight rows of in_count bytes, input bytes, and expected result bytes

// 4 inputs, 3 outputs, shift 2
00020304
03 fe 05 01
f9 04 00 02
0a 0a f6 fd
06 fb 02 09
0b f5 f6

// saturation layer, shift 0, sums far outside int8
00000202
7f 7f
80 80
7f 7f
7f 80

/* fc_accel.f */
logic/fc_pkg.sv
logic/buffer_ram.sv
logic/addr_decoder.sv
logic/fc_engine.sv
logic/fc_requant.sv
logic/fc_top.sv
test/tb_fc_top.sv

/* Makefile */
TOP := tb_fc_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f fc_accel.f

sim:
	verilator --binary --timing --top-module $(TOP) -f fc_accel.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
